//--- filelist.f
+incdir+source
source/mem_ctrl_pkg.sv
source/mem_req_if.sv
source/dram_cmd_if.sv
source/request_intake.sv
source/command_sequencer.sv
source/dram_device.sv
source/memory_subsystem.sv
testbench/memory_subsystem_properties.sv
testbench/memory_subsystem_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= memory_subsystem_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '** PASS **'

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/memory_subsystem_tb.sv
`include "mem_ctrl_consts.svh"

module memory_subsystem_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESET_CYCLES = 4;
	localparam int IDLE_CYCLES  = 6;

	typedef struct packed {
		logic                   we;
		logic [`MEM_ADDR_W-1:0] adr;
		logic [`MEM_DATA_W-1:0] dat_w;
		logic [1:0]             sel;
		logic                   expect_check;
	} entry_t;

	logic                   clk;
	logic                   reset;
	logic                   cyc;
	logic                   stb;
	logic                   we;
	logic                   ack;
	logic [`MEM_ADDR_W-1:0] adr;
	logic [`MEM_DATA_W-1:0] dat_w;
	logic [`MEM_DATA_W-1:0] dat_r;
	logic [1:0]             sel;

	entry_t                 stim_table [$];
	logic [`MEM_DATA_W-1:0] ref_mem [logic [`MEM_ADDR_W-1:0]]; // written words only
	int                     errors = 0;
	int                     ack_count = 0;
	int                     cycle_cnt = 0;
	int                     timeout_limit = 0;

	memory_subsystem memory_subsystem_inst (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	function automatic logic [`MEM_ADDR_W-1:0] make_adr(int bank, int row, int col);
		return {`MEM_BANK_W'(bank), `MEM_ROW_W'(row), `MEM_COL_W'(col)};
	endfunction

	task automatic add_entry(logic w, int bank, int row, int col, logic [15:0] data,
			logic [1:0] s);
		entry_t e;
		e.we           = w;
		e.adr          = make_adr(bank, row, col);
		e.dat_w        = data;
		e.sel          = s;
		e.expect_check = !w; // every read is checked
		stim_table.push_back(e);
	endtask

	task automatic build_table();
		// bank 0 starts closed
		add_entry(1'b1, 0, 0, 5, 16'($urandom), 2'b11);
		add_entry(1'b0, 0, 0, 5, '0, 2'b11);
		// hits in one open row
		for (int c = 0; c < 3; c++)
			add_entry(1'b1, 1, 1, c, 16'($urandom), 2'b11);
		for (int c = 2; c >= 0; c--)
			add_entry(1'b0, 1, 1, c, '0, 2'b11);
		// ping-pong between rows 0 and 2 of bank 2
		add_entry(1'b1, 2, 0, 10, 16'($urandom), 2'b11);
		add_entry(1'b1, 2, 2, 10, 16'($urandom), 2'b11);
		add_entry(1'b0, 2, 0, 10, '0, 2'b11);
		add_entry(1'b0, 2, 2, 10, '0, 2'b11);
		// same row and column in every bank
		for (int b = 0; b < `MEM_BANKS; b++)
			add_entry(1'b1, b, 3, 1, 16'($urandom), 2'b11);
		for (int b = `MEM_BANKS - 1; b >= 0; b--)
			add_entry(1'b0, b, 3, 1, '0, 2'b11);
		add_entry(1'b0, 0, 0, 5, '0, 2'b11); // first word survives it all
		// byte lanes
		add_entry(1'b1, 3, 1, 7, 16'ha5a5, 2'b11);
		add_entry(1'b1, 3, 1, 7, 16'h1234, 2'b01);
		add_entry(1'b0, 3, 1, 7, '0, 2'b11);
		add_entry(1'b1, 3, 1, 7, 16'hbeef, 2'b10);
		add_entry(1'b0, 3, 1, 7, '0, 2'b11);
	endtask

	// reference model merging by sel
	task automatic update_ref(entry_t e);
		logic [`MEM_DATA_W-1:0] word;
		word = '0;
		if (ref_mem.exists(e.adr))
			word = ref_mem[e.adr];
		else if (e.sel != 2'b11)
			return; // other byte still unknown
		for (int b = 0; b < 2; b++)
			if (e.sel[b])
				word[b*8 +: 8] = e.dat_w[b*8 +: 8];
		ref_mem[e.adr] = word;
	endtask

	task automatic run_entry(entry_t e);
		logic [`MEM_DATA_W-1:0] exp_data;
		@(posedge clk);
		cyc   <= 1'b1;
		stb   <= 1'b1;
		we    <= e.we;
		adr   <= e.adr;
		dat_w <= e.dat_w;
		sel   <= e.sel;
		@(posedge clk);
		while (!ack)
			@(posedge clk); // ack seen in the cycle just ended
		cyc <= 1'b0;
		stb <= 1'b0;
		if (e.we) begin
			update_ref(e);
		end else if (e.expect_check && ref_mem.exists(e.adr)) begin
			exp_data = ref_mem[e.adr];
			assert (dat_r == exp_data) else begin
				$display("[FAIL] dat_r=%h expected=%h adr=%h", dat_r, exp_data, e.adr);
				errors++;
			end
		end
	endtask

	task automatic check_idle();
		repeat (IDLE_CYCLES) begin
			@(posedge clk);
			assert (!ack) else begin
				$display("ack seen with no request pending");
				errors++;
			end
		end
	endtask

	// cycle limit and ack monitor
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (!reset && ack)
			ack_count <= ack_count + 1;
		if (timeout_limit > 0 && cycle_cnt >= timeout_limit) begin
			$display("timeout after %0d cycles, a request never completed", cycle_cnt);
			$display("** FAIL **");
			$finish;
		end
	end

	initial begin
		void'($urandom(32'hd0f72f3a)); // seeds the run
		reset = 1'b1;
		cyc   = 1'b0;
		stb   = 1'b0;
		we    = 1'b0;
		adr   = '0;
		dat_w = '0;
		sel   = '0;
		build_table();
		timeout_limit = stim_table.size() * 20 + RESET_CYCLES + 2 * IDLE_CYCLES;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		check_idle(); // nothing requested yet
		foreach (stim_table[i])
			run_entry(stim_table[i]);
		check_idle();
		assert (ack_count == stim_table.size()) else begin
			$display("got %0d acks for %0d requests", ack_count, stim_table.size());
			errors++;
		end
		$display("errors: %0d, acks: %0d of %0d", errors, ack_count, stim_table.size());
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

//--- testbench/memory_subsystem_properties.sv
`include "mem_ctrl_consts.svh"

module memory_subsystem_properties (
	input logic                    clk,
	input logic                    reset,
	input logic                    stb,
	input logic                    ack,
	input mem_ctrl_pkg::dram_cmd_t cmd,
	input logic [`MEM_BANK_W-1:0]  bank
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [3:0] since_act [`MEM_BANKS]; // cycles since ACT, 0 while closed
	logic [3:0] since_pre [`MEM_BANKS]; // cycles since PRE, saturates
	logic       is_col;

	assign is_col = (cmd == mem_ctrl_pkg::RD) || (cmd == mem_ctrl_pkg::WR);

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int b = 0; b < `MEM_BANKS; b++) begin
				since_act[b] <= '0;
				since_pre[b] <= '1; // no precharge seen yet
			end
		end else begin
			for (int b = 0; b < `MEM_BANKS; b++) begin
				if (since_act[b] != '0 && since_act[b] != '1)
					since_act[b] <= since_act[b] + 4'd1;
				if (since_pre[b] != '1)
					since_pre[b] <= since_pre[b] + 4'd1;
			end
			if (cmd == mem_ctrl_pkg::ACT)
				since_act[bank] <= 4'd1;
			if (cmd == mem_ctrl_pkg::PRE) begin
				since_act[bank] <= '0; // bank closed again
				since_pre[bank] <= 4'd1;
			end
		end
	end

	// wishbone side
	ack_needs_stb: assert property (@(posedge clk) disable iff (reset) ack |-> stb)
		else $error("ack raised while stb is low");
	ack_single: assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
		else $error("ack held longer than one cycle");

	// command bus spacing
	col_after_rcd: assert property (@(posedge clk) disable iff (reset)
		is_col |-> since_act[bank] >= 4'(`T_RCD))
		else $error("column command before tRCD elapsed on bank %0d", bank);
	act_after_rp: assert property (@(posedge clk) disable iff (reset)
		cmd == mem_ctrl_pkg::ACT |-> since_pre[bank] >= 4'(`T_RP))
		else $error("activate before tRP elapsed on bank %0d", bank);

endmodule

bind memory_subsystem memory_subsystem_properties memory_subsystem_properties_inst (
	.clk   (clk),
	.reset (reset),
	.stb   (stb),
	.ack   (ack),
	.cmd   (cmd_bus.cmd),
	.bank  (cmd_bus.bank)
);

//--- source/memory_subsystem.sv
`include "mem_ctrl_consts.svh"

module memory_subsystem (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   cyc,
	input  logic                   stb,
	input  logic                   we,
	input  logic [`MEM_ADDR_W-1:0] adr,
	input  logic [`MEM_DATA_W-1:0] dat_w,
	input  logic [1:0]             sel,
	output logic                   ack,
	output logic [`MEM_DATA_W-1:0] dat_r
);
	mem_req_if  req_bus ();
	dram_cmd_if cmd_bus ();

	// wishbone in, one decoded request out
	request_intake request_intake_inst (
		.clk   (clk),
		.reset (reset),
		.cyc   (cyc),
		.stb   (stb),
		.we    (we),
		.adr   (adr),
		.dat_w (dat_w),
		.sel   (sel),
		.ack   (ack),
		.dat_r (dat_r),
		.req   (req_bus.intake)
	);

	command_sequencer command_sequencer_inst (
		.clk   (clk),
		.reset (reset),
		.req   (req_bus.sequencer),
		.cmd   (cmd_bus.controller)
	);

	dram_device dram_device_inst (
		.clk   (clk),
		.reset (reset),
		.cmd   (cmd_bus.device)
	);

endmodule

//--- source/dram_device.sv
`include "mem_ctrl_consts.svh"

module dram_device (
	input  logic       clk,
	input  logic       reset,
	dram_cmd_if.device cmd
);
	localparam int DEV_ROW_W = $clog2(`MEM_DEV_ROWS);
	localparam int COLS      = 1 << `MEM_COL_W;

	// storage, upper row bits alias
	logic [`MEM_DATA_W-1:0] mem [`MEM_BANKS][`MEM_DEV_ROWS][COLS];
	logic [DEV_ROW_W-1:0]   act_row [`MEM_BANKS]; // row latched by ACT
	logic [`MEM_DATA_W-1:0] rd_pipe [`T_CL];
	logic [`T_CL-1:0]       rv_pipe;
	logic [DEV_ROW_W-1:0]   cur_row;
	logic [`MEM_COL_W-1:0]  cur_col;

	assign cur_row = act_row[cmd.bank];
	assign cur_col = cmd.addr[`MEM_COL_W-1:0];

	always_ff @(posedge clk) begin
		if (reset) begin
			rv_pipe <= '0;
			for (int b = 0; b < `MEM_BANKS; b++)
				act_row[b] <= '0;
		end else begin
			if (cmd.cmd == mem_ctrl_pkg::ACT)
				act_row[cmd.bank] <= cmd.addr[DEV_ROW_W-1:0];
			rv_pipe <= {rv_pipe[`T_CL-2:0], cmd.cmd == mem_ctrl_pkg::RD};
		end
	end

	// array and data stages, contents survive reset
	always_ff @(posedge clk) begin
		if (cmd.cmd == mem_ctrl_pkg::WR) begin
			for (int b = 0; b < `MEM_DM_W; b++) begin
				if (!cmd.dm_n[b])
					mem[cmd.bank][cur_row][cur_col][b*8 +: 8] <= cmd.wdata[b*8 +: 8];
			end
		end
		if (cmd.cmd == mem_ctrl_pkg::RD)
			rd_pipe[0] <= mem[cmd.bank][cur_row][cur_col];
		for (int s = 1; s < `T_CL; s++)
			rd_pipe[s] <= rd_pipe[s-1]; // cas latency shift
	end

	assign cmd.rdata  = rd_pipe[`T_CL-1];
	assign cmd.rvalid = rv_pipe[`T_CL-1];

endmodule

//--- source/command_sequencer.sv
`include "mem_ctrl_consts.svh"

module command_sequencer (
	input  logic           clk,
	input  logic           reset,
	mem_req_if.sequencer   req,
	dram_cmd_if.controller cmd
);
	typedef enum logic [2:0] {
		IDLE,
		PRECHARGE,
		WAIT_RP,
		ACTIVATE,
		WAIT_RCD,
		ISSUE,
		WAIT_CL
	} seq_state_t;

	seq_state_t                state;
	logic [2:0]                cnt;     // shared tRP / tRCD / CL counter
	logic                      wr_done; // pulse the cycle after WR
	mem_ctrl_pkg::bank_state_t banks [`MEM_BANKS];
	mem_ctrl_pkg::bank_state_t cur_bank;
	logic                      row_hit;

	assign cur_bank = banks[req.req.bank];
	assign row_hit  = cur_bank.open && (cur_bank.row == req.req.row);

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= IDLE;
			cnt     <= '0;
			wr_done <= 1'b0;
			for (int b = 0; b < `MEM_BANKS; b++)
				banks[b] <= '0; // all banks closed
		end else begin
			wr_done <= 1'b0;
			case (state)
				IDLE: begin
					// req_valid is still up while done is out
					if (req.req_valid && !wr_done) begin
						if (row_hit)
							state <= ISSUE;
						else if (!cur_bank.open)
							state <= ACTIVATE;
						else
							state <= PRECHARGE; // row conflict
					end
				end
				PRECHARGE: begin
					banks[req.req.bank].open <= 1'b0;
					cnt   <= 3'(`T_RP - 2); // wait state covers the middle cycles
					state <= WAIT_RP;
				end
				WAIT_RP: begin
					if (cnt == '0)
						state <= ACTIVATE;
					else
						cnt <= cnt - 3'd1;
				end
				ACTIVATE: begin
					banks[req.req.bank].open <= 1'b1;
					banks[req.req.bank].row  <= req.req.row;
					cnt   <= 3'(`T_RCD - 2);
					state <= WAIT_RCD;
				end
				WAIT_RCD: begin
					if (cnt == '0)
						state <= ISSUE;
					else
						cnt <= cnt - 3'd1;
				end
				ISSUE: begin
					if (req.req.we) begin
						wr_done <= 1'b1;
						state   <= IDLE;
					end else begin
						cnt   <= 3'(`T_CL - 1); // reaches zero as data lands
						state <= WAIT_CL;
					end
				end
				WAIT_CL: begin
					if (cnt == '0)
						state <= IDLE;
					else
						cnt <= cnt - 3'd1;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// command decode straight from state
	always_comb begin
		cmd.cmd  = mem_ctrl_pkg::NOP;
		cmd.addr = '0;
		case (state)
			PRECHARGE: cmd.cmd = mem_ctrl_pkg::PRE;
			ACTIVATE: begin
				cmd.cmd  = mem_ctrl_pkg::ACT;
				cmd.addr = req.req.row;
			end
			ISSUE: begin
				cmd.cmd  = req.req.we ? mem_ctrl_pkg::WR : mem_ctrl_pkg::RD;
				cmd.addr = `MEM_ROW_W'(req.req.col); // column rides the low bits
			end
			default: cmd.cmd = mem_ctrl_pkg::NOP;
		endcase
	end

	// request payload is held steady by the intake
	assign cmd.bank  = req.req.bank;
	assign cmd.wdata = req.req.wdata;
	assign cmd.dm_n  = req.req.dm_n;

	assign req.req_done = wr_done || (state == WAIT_CL && cmd.rvalid);
	assign req.rdata    = cmd.rdata;

endmodule

//--- source/request_intake.sv
`include "mem_ctrl_consts.svh"

module request_intake (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   cyc,
	input  logic                   stb,
	input  logic                   we,
	input  logic [`MEM_ADDR_W-1:0] adr,
	input  logic [`MEM_DATA_W-1:0] dat_w,
	input  logic [1:0]             sel,
	output logic                   ack,
	output logic [`MEM_DATA_W-1:0] dat_r,
	mem_req_if.intake              req
);
	logic                   busy;  // request out at the sequencer
	logic                   take;  // capture strobe
	mem_ctrl_pkg::mem_req_t req_q;

	// host still holds stb during the ack cycle, so skip it
	assign take = cyc && stb && !busy && !ack;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			ack  <= 1'b0;
		end else begin
			ack <= busy && req.req_done; // registered, one cycle after done
			if (take)
				busy <= 1'b1;
			else if (req.req_done)
				busy <= 1'b0;
		end
	end

	// address slicing, bank on top
	always_ff @(posedge clk) begin
		if (take) begin
			req_q.we    <= we;
			req_q.bank  <= adr[`MEM_ADDR_W-1 -: `MEM_BANK_W];
			req_q.row   <= adr[`MEM_COL_W +: `MEM_ROW_W];
			req_q.col   <= adr[`MEM_COL_W-1:0];
			req_q.wdata <= dat_w;
			req_q.dm_n  <= ~sel; // wishbone sel is active high
		end
		if (req.req_done && !req_q.we)
			dat_r <= req.rdata; // lines up with ack
	end

	assign req.req_valid = busy;
	assign req.req       = req_q;

endmodule

//--- source/dram_cmd_if.sv
`include "mem_ctrl_consts.svh"

// command bus to the device, no back-pressure
interface dram_cmd_if;
	mem_ctrl_pkg::dram_cmd_t cmd;   // NOP when idle
	logic [`MEM_BANK_W-1:0]  bank;
	logic [`MEM_ROW_W-1:0]   addr;  // row on ACT, column on RD/WR
	logic [`MEM_DATA_W-1:0]  wdata;
	logic [`MEM_DM_W-1:0]    dm_n;
	logic [`MEM_DATA_W-1:0]  rdata;
	logic                    rvalid; // T_CL cycles after RD

	modport controller (
		output cmd,
		output bank,
		output addr,
		output wdata,
		output dm_n,
		input  rdata,
		input  rvalid
	);

	modport device (
		input  cmd,
		input  bank,
		input  addr,
		input  wdata,
		input  dm_n,
		output rdata,
		output rvalid
	);
endinterface

//--- source/mem_req_if.sv
`include "mem_ctrl_consts.svh"

// one request at a time from intake to sequencer, completion back
interface mem_req_if;
	logic                   req_valid; // held until req_done
	mem_ctrl_pkg::mem_req_t req;
	logic                   req_done;  // single cycle
	logic [`MEM_DATA_W-1:0] rdata;     // valid with req_done on reads

	modport intake (
		output req_valid,
		output req,
		input  req_done,
		input  rdata
	);

	modport sequencer (
		input  req_valid,
		input  req,
		output req_done,
		output rdata
	);
endinterface

//--- source/mem_ctrl_pkg.sv
`include "mem_ctrl_consts.svh"

package mem_ctrl_pkg;

	// command bus encoding
	typedef enum logic [2:0] {
		NOP = 3'd0,
		ACT = 3'd1,
		PRE = 3'd2,
		RD  = 3'd3,
		WR  = 3'd4
	} dram_cmd_t;

	// decoded host request, 43 bits
	typedef struct packed {
		logic                   we;
		logic [`MEM_BANK_W-1:0] bank;
		logic [`MEM_ROW_W-1:0]  row;
		logic [`MEM_COL_W-1:0]  col;
		logic [`MEM_DATA_W-1:0] wdata;
		logic [`MEM_DM_W-1:0]   dm_n; // low = write this byte
	} mem_req_t;

	// per bank open row tracking
	typedef struct packed {
		logic                  open;
		logic [`MEM_ROW_W-1:0] row;
	} bank_state_t;

endpackage

//--- source/mem_ctrl_consts.svh
`ifndef MEM_CTRL_CONSTS_SVH
`define MEM_CTRL_CONSTS_SVH

// host side widths
`define MEM_DATA_W 16
`define MEM_ADDR_W 24
`define MEM_DM_W (`MEM_DATA_W / 8) // one mask bit per byte

// address split, bank on top then row then column
`define MEM_BANKS 4
`define MEM_BANK_W 2
`define MEM_ROW_W 14
`define MEM_COL_W 8

// rows per bank the device model really stores
`define MEM_DEV_ROWS 4

// dram timing in clk cycles
`define T_RP 2  // precharge to activate
`define T_RCD 3 // activate to column command
`define T_CL 4  // read command to data

`endif
